// File: source/tankArena_defs.svh
`ifndef TANKARENA_DEFS_SVH
`define TANKARENA_DEFS_SVH

////////////////////////////////
// Screen and tile geometry
////////////////////////////////

// Last visible column and row, inclusive
`define SCREEN_WIDTH  640
`define SCREEN_HEIGHT 480

// 32x32 pixel tiles on a 20x15 grid
`define TILE_SHIFT 5
`define MAP_COLS   20
`define MAP_ROWS   15

// Tank box spans origin to origin plus this offset
`define TANK_WIDTH 25
// Spawn point, same for x and y
`define TANK_START 5

////////////////////////////////
// 12-bit RGB shades
////////////////////////////////

`define COLOR_TANK   12'h2C2
`define COLOR_EMPTY  12'hEEE
`define COLOR_WALL   12'h555
`define COLOR_BRICK  12'hA52
`define COLOR_COIN   12'hFD0
// Codes 4 to 7
`define COLOR_HAZARD 12'hF44
`define COLOR_OTHER  12'h888
// Outside the visible limits
`define COLOR_BORDER 12'h222

`endif

// File: source/tankArenaPkg.sv
`default_nettype none
`include "tankArena_defs.svh"

package tankArenaPkg;

	// Scalar widths
	typedef logic [9:0] coordT;
	typedef logic [3:0] tileCodeT;
	typedef logic [7:0] coinCountT;

	// Grid position of a pixel
	typedef struct packed
	{
		logic [4:0] tileCol;
		logic [3:0] tileRow;
	} tileIndexT;

	// Tank origin, top-left corner
	typedef struct packed
	{
		coordT tankX;
		coordT tankY;
	} tankPosT;

	// One decoded pixel of the scan
	typedef struct packed
	{
		coordT     pixelX;
		coordT     pixelY;
		tileIndexT tile;
		logic      visible;
		logic      inRange;
	} pixelT;

	typedef struct packed
	{
		logic [3:0] red;
		logic [3:0] green;
		logic [3:0] blue;
	} colorT;

	typedef struct packed
	{
		logic up;
		logic down;
		logic left;
		logic right;
	} buttonsT;

	typedef enum logic [2:0] {IDLE, WRAP, PROBE, RESOLVE, DONE} motionStateT;

	// Pixel coordinate to tile, folded into the map range
	function automatic tileIndexT tileOf(coordT x, coordT y);
		tileIndexT idx;
		idx.tileCol = 5'((x >> `TILE_SHIFT) % `MAP_COLS);
		idx.tileRow = 4'((y >> `TILE_SHIFT) % `MAP_ROWS);
		return idx;
	endfunction

endpackage

`default_nettype wire

// File: source/tileMap.sv
`default_nettype none
`include "tankArena_defs.svh"

module tileMap
(
	input  wire logic                   Master_Clock_In,
	input  wire logic                   rstN,
	input  wire tankArenaPkg::tileIndexT pixelIndex,
	input  wire tankArenaPkg::tileIndexT probeIndex,
	input  wire tankArenaPkg::tileIndexT clearIndex,
	input  wire logic                   clearEn,
	output tankArenaPkg::tileCodeT      pixelTile,
	output tankArenaPkg::tileCodeT      probeTile
);

	////////////////////////////////
	// Start layout
	////////////////////////////////

	// One hex digit per tile, column 0 leftmost
	// Outer ring empty, bricks (2) and coins (3) inside
	localparam logic [79:0] mapLayout [`MAP_ROWS] = '{
		80'h0000000000_0000000000,
		80'h0232322323_3232232320,
		80'h0332333323_3233332330,
		80'h0222222323_3232222220,
		80'h0332333323_3233332330,
		80'h0232322322_2232232330,
		80'h0333333333_3333333330,
		80'h0222223222_2223222220,
		80'h0333333333_3333333330,
		80'h0232322322_2232232320,
		80'h0332333323_3233332330,
		80'h0222222323_3232222220,
		80'h0332333323_3233332330,
		80'h0232322323_3232232320,
		80'h0000000000_0000000000
	};

	// Live map, coins get cleared here
	tankArenaPkg::tileCodeT mapMem [`MAP_ROWS][`MAP_COLS];

	////////////////////////////////
	// Reload and clear
	////////////////////////////////

	always_ff @(posedge Master_Clock_In)
	begin
		if (!rstN)
		begin
			// Whole layout comes back on reset
			for (int r = 0; r < `MAP_ROWS; r++)
			begin
				for (int c = 0; c < `MAP_COLS; c++)
				begin
					mapMem[r][c] <= mapLayout[r][79 - 4*c -: 4];
				end
			end
		end
		else if (clearEn)
		begin
			// Collected coin becomes empty floor
			mapMem[clearIndex.tileRow][clearIndex.tileCol] <= '0;
		end
	end

	// Two independent combinational reads
	assign pixelTile = mapMem[pixelIndex.tileRow][pixelIndex.tileCol];
	assign probeTile = mapMem[probeIndex.tileRow][probeIndex.tileCol];

	// Clear requests from the motion logic stay on the grid
	clearInMap: assert property (@(posedge Master_Clock_In) disable iff (!rstN)
		clearEn |-> (clearIndex.tileCol < `MAP_COLS) && (clearIndex.tileRow < `MAP_ROWS));

endmodule

`default_nettype wire

// File: source/pixelDecode.sv
`default_nettype none
`include "tankArena_defs.svh"

module pixelDecode
(
	input  wire logic               Master_Clock_In,
	input  wire logic               rstN,
	input  wire logic               dispEna,
	input  wire tankArenaPkg::coordT pixelX,
	input  wire tankArenaPkg::coordT pixelY,
	input  wire logic               stepAck,
	output tankArenaPkg::pixelT     pixelStage,
	output logic                    stepReq
);

	// Last visible pixel of the frame
	logic endOfFrame;

	assign endOfFrame = dispEna
		&& (pixelX == tankArenaPkg::coordT'(`SCREEN_WIDTH))
		&& (pixelY == tankArenaPkg::coordT'(`SCREEN_HEIGHT));

	////////////////////////////////
	// Pixel stage
	////////////////////////////////

	always_ff @(posedge Master_Clock_In)
	begin
		pixelStage.pixelX  <= pixelX;
		pixelStage.pixelY  <= pixelY;
		pixelStage.tile    <= tankArenaPkg::tileOf(pixelX, pixelY);
		pixelStage.visible <= dispEna;
		// Limits are inclusive
		pixelStage.inRange <= (pixelX <= tankArenaPkg::coordT'(`SCREEN_WIDTH))
			&& (pixelY <= tankArenaPkg::coordT'(`SCREEN_HEIGHT));
	end

	////////////////////////////////
	// Step request, four-phase
	////////////////////////////////

	always_ff @(posedge Master_Clock_In)
	begin
		if (!rstN)
			stepReq <= 1'b0;
		else if (stepReq && stepAck)
			stepReq <= 1'b0;
		// Only start from rest, late frames are dropped
		else if (!stepReq && !stepAck && endOfFrame)
			stepReq <= 1'b1;
	end

	// Request is held until the motion side acknowledges
	reqHeldForAck: assert property (@(posedge Master_Clock_In) disable iff (!rstN)
		$fell(stepReq) |-> $past(stepAck));

endmodule

`default_nettype wire

// File: source/tankMotion.sv
`default_nettype none
`include "tankArena_defs.svh"

module tankMotion
(
	input  wire logic                   Master_Clock_In,
	input  wire logic                   rstN,
	input  wire logic                   stepReq,
	input  wire tankArenaPkg::buttonsT   buttons,
	input  wire tankArenaPkg::tileCodeT  probeTile,
	output tankArenaPkg::tileIndexT     probeIndex,
	output logic                        clearEn,
	output tankArenaPkg::tileIndexT     clearIndex,
	output logic                        stepAck,
	output tankArenaPkg::tankPosT       tankPos,
	output tankArenaPkg::coinCountT     coinValue
);

	tankArenaPkg::motionStateT state;
	logic [1:0]                probeCnt;
	// Corner codes in TL, TR, BL, BR order
	tankArenaPkg::tileCodeT    corners [4];
	logic [3:0]                solid;
	logic                      coinHit;
	logic [1:0]                coinCorner;
	tankArenaPkg::tankPosT     nextPos;

	// Tile under one corner, bit 0 picks right, bit 1 picks bottom
	function automatic tankArenaPkg::tileIndexT cornerTile(tankArenaPkg::tankPosT pos,
		logic [1:0] corner);
		tankArenaPkg::coordT cx;
		tankArenaPkg::coordT cy;
		cx = corner[0] ? tankArenaPkg::coordT'(pos.tankX + `TANK_WIDTH) : pos.tankX;
		cy = corner[1] ? tankArenaPkg::coordT'(pos.tankY + `TANK_WIDTH) : pos.tankY;
		return tankArenaPkg::tileOf(cx, cy);
	endfunction

	// Screen edge wrap for one axis
	function automatic tankArenaPkg::coordT wrapCoord(tankArenaPkg::coordT c, int limit);
		if (c == '0)
			return tankArenaPkg::coordT'(limit - `TANK_WIDTH - 1);
		else if (c == tankArenaPkg::coordT'(limit - `TANK_WIDTH))
			return tankArenaPkg::coordT'(1);
		return c;
	endfunction

	assign probeIndex = cornerTile(tankPos, probeCnt);
	assign clearIndex = cornerTile(tankPos, coinCorner);
	assign stepAck    = (state == tankArenaPkg::DONE);
	// Coin only counts when no corner is blocked
	assign clearEn    = (state == tankArenaPkg::RESOLVE) && (solid == '0) && coinHit;

	////////////////////////////////
	// Resolve rules
	////////////////////////////////

	always_comb
	begin
		for (int k = 0; k < 4; k++)
			solid[k] = (corners[k] == 4'd1) || (corners[k] == 4'd2);
		// First coin corner wins
		coinHit    = 1'b1;
		coinCorner = 2'd0;
		if (corners[0] == 4'd3)
			coinCorner = 2'd0;
		else if (corners[1] == 4'd3)
			coinCorner = 2'd1;
		else if (corners[2] == 4'd3)
			coinCorner = 2'd2;
		else if (corners[3] == 4'd3)
			coinCorner = 2'd3;
		else
			coinHit = 1'b0;

		nextPos = tankPos;
		// Edge pairs first, then single corners
		if (solid[2] && solid[3])
			nextPos.tankY = tankPos.tankY - 1'b1;
		else if (solid[0] && solid[2])
			nextPos.tankX = tankPos.tankX + 1'b1;
		else if (solid[0] && solid[1])
			nextPos.tankY = tankPos.tankY + 1'b1;
		else if (solid[1] && solid[3])
			nextPos.tankX = tankPos.tankX - 1'b1;
		else if (solid[0])
			nextPos = '{tankX: tankPos.tankX + 1'b1, tankY: tankPos.tankY + 1'b1};
		else if (solid[1])
			nextPos = '{tankX: tankPos.tankX - 1'b1, tankY: tankPos.tankY + 1'b1};
		else if (solid[2])
			nextPos = '{tankX: tankPos.tankX + 1'b1, tankY: tankPos.tankY - 1'b1};
		else if (solid[3])
			nextPos = '{tankX: tankPos.tankX - 1'b1, tankY: tankPos.tankY - 1'b1};
		// Buttons only when nothing else happened, up has priority
		else if (!coinHit)
		begin
			if (buttons.up)
				nextPos.tankY = tankPos.tankY - 1'b1;
			else if (buttons.right)
				nextPos.tankX = tankPos.tankX + 1'b1;
			else if (buttons.down)
				nextPos.tankY = tankPos.tankY + 1'b1;
			else if (buttons.left)
				nextPos.tankX = tankPos.tankX - 1'b1;
		end
	end

	////////////////////////////////
	// Step FSM
	////////////////////////////////

	always_ff @(posedge Master_Clock_In)
	begin
		if (!rstN)
		begin
			state     <= tankArenaPkg::IDLE;
			probeCnt  <= '0;
			tankPos   <= '{tankX: `TANK_START, tankY: `TANK_START};
			coinValue <= '0;
		end
		else
		begin
			case (state)
				tankArenaPkg::IDLE:
					if (stepReq)
						state <= tankArenaPkg::WRAP;
				tankArenaPkg::WRAP:
				begin
					tankPos.tankX <= wrapCoord(tankPos.tankX, `SCREEN_WIDTH);
					tankPos.tankY <= wrapCoord(tankPos.tankY, `SCREEN_HEIGHT);
					probeCnt      <= '0;
					state         <= tankArenaPkg::PROBE;
				end
				tankArenaPkg::PROBE:
				begin
					// One corner per cycle
					probeCnt <= probeCnt + 1'b1;
					if (probeCnt == 2'd3)
						state <= tankArenaPkg::RESOLVE;
				end
				tankArenaPkg::RESOLVE:
				begin
					tankPos <= nextPos;
					if (clearEn)
						coinValue <= coinValue + 1'b1;
					state <= tankArenaPkg::DONE;
				end
				tankArenaPkg::DONE:
					// Ack stays up until the request drops
					if (!stepReq)
						state <= tankArenaPkg::IDLE;
				default:
					state <= tankArenaPkg::IDLE;
			endcase
		end
	end

	// Corner codes, latched as the probe walks
	always_ff @(posedge Master_Clock_In)
	begin
		if (state == tankArenaPkg::PROBE)
			corners[probeCnt] <= probeTile;
	end

	// Ack never rises without a pending request
	ackNeedsReq: assert property (@(posedge Master_Clock_In) disable iff (!rstN)
		$rose(stepAck) |-> stepReq);

endmodule

`default_nettype wire

// File: source/pixelShade.sv
`default_nettype none
`include "tankArena_defs.svh"

module pixelShade
(
	input  wire logic                  Master_Clock_In,
	input  wire logic                  rstN,
	input  wire tankArenaPkg::pixelT    pixelStage,
	input  wire tankArenaPkg::tileCodeT pixelTile,
	input  wire tankArenaPkg::tankPosT  tankPos,
	output tankArenaPkg::colorT        pixelColor
);

	tankArenaPkg::colorT tileColor;
	tankArenaPkg::colorT nextColor;
	logic                inTank;

	// Flat shade per tile code
	always_comb
	begin
		case (pixelTile)
			4'd0:
				tileColor = tankArenaPkg::colorT'(`COLOR_EMPTY);
			4'd1:
				tileColor = tankArenaPkg::colorT'(`COLOR_WALL);
			4'd2:
				tileColor = tankArenaPkg::colorT'(`COLOR_BRICK);
			4'd3:
				tileColor = tankArenaPkg::colorT'(`COLOR_COIN);
			4'd4, 4'd5, 4'd6, 4'd7:
				tileColor = tankArenaPkg::colorT'(`COLOR_HAZARD);
			default:
				tileColor = tankArenaPkg::colorT'(`COLOR_OTHER);
		endcase
	end

	// Inclusive tank box
	assign inTank = (pixelStage.pixelX >= tankPos.tankX)
		&& (pixelStage.pixelX <= tankPos.tankX + `TANK_WIDTH)
		&& (pixelStage.pixelY >= tankPos.tankY)
		&& (pixelStage.pixelY <= tankPos.tankY + `TANK_WIDTH);

	////////////////////////////////
	// Colour priority
	////////////////////////////////

	always_comb
	begin
		if (!pixelStage.visible)
			nextColor = '0;
		else if (!pixelStage.inRange)
			nextColor = tankArenaPkg::colorT'(`COLOR_BORDER);
		else if (inTank)
			nextColor = tankArenaPkg::colorT'(`COLOR_TANK);
		else
			nextColor = tileColor;
	end

	// Second stage of the pixel pipe
	always_ff @(posedge Master_Clock_In)
	begin
		if (!rstN)
			pixelColor <= '0;
		else
			pixelColor <= nextColor;
	end

endmodule

`default_nettype wire

// File: source/tankArena.sv
`default_nettype none

module tankArena
(
	input  wire logic                  Master_Clock_In,
	input  wire logic                  rstN,
	input  wire logic                  dispEna,
	input  wire tankArenaPkg::coordT    pixelX,
	input  wire tankArenaPkg::coordT    pixelY,
	input  wire tankArenaPkg::buttonsT  buttons,
	output tankArenaPkg::colorT        pixelColor,
	output tankArenaPkg::coinCountT    coinValue
);

	// Pixel path
	tankArenaPkg::pixelT     pixelStage;
	tankArenaPkg::tileCodeT  pixelTile;
	// Probe and clear path
	tankArenaPkg::tileCodeT  probeTile;
	tankArenaPkg::tileIndexT probeIndex;
	tankArenaPkg::tileIndexT clearIndex;
	logic                    clearEn;
	tankArenaPkg::tankPosT   tankPos;
	// Frame step handshake
	logic                    stepReq;
	logic                    stepAck;

	pixelDecode decode (
		.Master_Clock_In(Master_Clock_In),
		.rstN(rstN),
		.dispEna(dispEna),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.stepAck(stepAck),
		.pixelStage(pixelStage),
		.stepReq(stepReq)
	);

	tileMap mapStore (
		.Master_Clock_In(Master_Clock_In),
		.rstN(rstN),
		.pixelIndex(pixelStage.tile),
		.probeIndex(probeIndex),
		.clearIndex(clearIndex),
		.clearEn(clearEn),
		.pixelTile(pixelTile),
		.probeTile(probeTile)
	);

	tankMotion execute (
		.Master_Clock_In(Master_Clock_In),
		.rstN(rstN),
		.stepReq(stepReq),
		.buttons(buttons),
		.probeTile(probeTile),
		.probeIndex(probeIndex),
		.clearEn(clearEn),
		.clearIndex(clearIndex),
		.stepAck(stepAck),
		.tankPos(tankPos),
		.coinValue(coinValue)
	);

	pixelShade result (
		.Master_Clock_In(Master_Clock_In),
		.rstN(rstN),
		.pixelStage(pixelStage),
		.pixelTile(pixelTile),
		.tankPos(tankPos),
		.pixelColor(pixelColor)
	);

endmodule

`default_nettype wire

// File: test/tankArenaModel.svh
`ifndef TANKARENAMODEL_SVH
`define TANKARENAMODEL_SVH

	////////////////////////////////
	// Reference arena state
	////////////////////////////////

	int refMap [`MAP_ROWS][`MAP_COLS];
	int refX;
	int refY;
	int refCoins;

	// Start layout, one hex digit per tile, column 0 leftmost
	function automatic logic [79:0] layoutRow(int r);
		case (r)
			1, 13:
				return 80'h0232322323_3232232320;
			2, 4, 10, 12:
				return 80'h0332333323_3233332330;
			3, 11:
				return 80'h0222222323_3232222220;
			5:
				return 80'h0232322322_2232232330;
			6, 8:
				return 80'h0333333333_3333333330;
			7:
				return 80'h0222223222_2223222220;
			9:
				return 80'h0232322322_2232232320;
			// Top and bottom rows are open floor
			default:
				return '0;
		endcase
	endfunction

	function automatic void resetModel();
		logic [79:0] row;
		for (int r = 0; r < `MAP_ROWS; r++)
		begin
			row = layoutRow(r);
			for (int c = 0; c < `MAP_COLS; c++)
				refMap[r][c] = row[79 - 4*c -: 4];
		end
		refX     = `TANK_START;
		refY     = `TANK_START;
		refCoins = 0;
	endfunction

	// Tile code under a pixel, grid folds over the map size
	function automatic int codeAt(int x, int y);
		int col;
		int row;
		col = ((x & 1023) >> `TILE_SHIFT) % `MAP_COLS;
		row = ((y & 1023) >> `TILE_SHIFT) % `MAP_ROWS;
		return refMap[row][col];
	endfunction

	// Expected shade of one pixel
	function automatic tankArenaPkg::colorT expectedColor(logic ena, int x, int y);
		int px;
		int py;
		px = x & 1023;
		py = y & 1023;
		if (!ena)
			return '0;
		if (px > `SCREEN_WIDTH || py > `SCREEN_HEIGHT)
			return tankArenaPkg::colorT'(`COLOR_BORDER);
		if (px >= refX && px <= refX + `TANK_WIDTH && py >= refY && py <= refY + `TANK_WIDTH)
			return tankArenaPkg::colorT'(`COLOR_TANK);
		case (codeAt(px, py))
			0:
				return tankArenaPkg::colorT'(`COLOR_EMPTY);
			1:
				return tankArenaPkg::colorT'(`COLOR_WALL);
			2:
				return tankArenaPkg::colorT'(`COLOR_BRICK);
			3:
				return tankArenaPkg::colorT'(`COLOR_COIN);
			4, 5, 6, 7:
				return tankArenaPkg::colorT'(`COLOR_HAZARD);
			default:
				return tankArenaPkg::colorT'(`COLOR_OTHER);
		endcase
	endfunction

	// One frame step: wrap, four corners, then collision, coin or buttons
	function automatic void applyStep(tankArenaPkg::buttonsT press);
		int cx [4];
		int cy [4];
		int code [4];
		logic [3:0] solid;
		int coin;
		if (refX == 0)
			refX = `SCREEN_WIDTH - `TANK_WIDTH - 1;
		else if (refX == `SCREEN_WIDTH - `TANK_WIDTH)
			refX = 1;
		if (refY == 0)
			refY = `SCREEN_HEIGHT - `TANK_WIDTH - 1;
		else if (refY == `SCREEN_HEIGHT - `TANK_WIDTH)
			refY = 1;
		coin = -1;
		// Corners in TL, TR, BL, BR order
		for (int k = 0; k < 4; k++)
		begin
			cx[k]    = refX + ((k % 2 == 1) ? `TANK_WIDTH : 0);
			cy[k]    = refY + ((k >= 2) ? `TANK_WIDTH : 0);
			code[k]  = codeAt(cx[k], cy[k]);
			solid[k] = (code[k] == 1) || (code[k] == 2);
			if (coin < 0 && code[k] == 3)
				coin = k;
		end
		if (solid[2] && solid[3])
			refY--;
		else if (solid[0] && solid[2])
			refX++;
		else if (solid[0] && solid[1])
			refY++;
		else if (solid[1] && solid[3])
			refX--;
		else if (solid[0])
		begin
			refX++;
			refY++;
		end
		else if (solid[1])
		begin
			refX--;
			refY++;
		end
		else if (solid[2])
		begin
			refX++;
			refY--;
		end
		else if (solid[3])
		begin
			refX--;
			refY--;
		end
		else if (coin >= 0)
		begin
			refMap[((cy[coin] & 1023) >> `TILE_SHIFT) % `MAP_ROWS]
				[((cx[coin] & 1023) >> `TILE_SHIFT) % `MAP_COLS] = 0;
			refCoins++;
		end
		// Up beats right beats down beats left
		else if (press.up)
			refY--;
		else if (press.right)
			refX++;
		else if (press.down)
			refY++;
		else if (press.left)
			refX--;
		refX     = refX & 1023;
		refY     = refY & 1023;
		refCoins = refCoins & 255;
	endfunction

`endif

// File: test/tankArenaTb.sv
`default_nettype none
`include "tankArena_defs.svh"

module tankArenaTb;

	logic                    Master_Clock_In;
	logic                    rstN;
	logic                    dispEna;
	tankArenaPkg::coordT     pixelX;
	tankArenaPkg::coordT     pixelY;
	tankArenaPkg::buttonsT   buttons;
	tankArenaPkg::colorT     pixelColor;
	tankArenaPkg::coinCountT coinValue;

	// Pixel driven this cycle and its expected shade
	logic                curValid;
	tankArenaPkg::colorT curExp;
	int                  curX;
	int                  curY;
	// Two-stage delay line, same depth as the DUT pixel pipe
	logic                pipeValid [2];
	tankArenaPkg::colorT pipeExp [2];
	int                  pipeX [2];
	int                  pipeY [2];

	int colorErrors;
	int coinErrors;
	int timeoutErrors;

	`include "tankArenaModel.svh"

	tankArena UUT (
		.Master_Clock_In(Master_Clock_In),
		.rstN(rstN),
		.dispEna(dispEna),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.buttons(buttons),
		.pixelColor(pixelColor),
		.coinValue(coinValue)
	);

	initial
	begin
		Master_Clock_In = 1'b0;
		forever
			#10 Master_Clock_In = ~Master_Clock_In;
	end

	////////////////////////////////
	// Compare tasks
	////////////////////////////////

	task automatic checkColor(tankArenaPkg::colorT got, tankArenaPkg::colorT exp, int x, int y);
		if (got !== exp)
		begin
			colorErrors++;
			$display("[FAIL] %0t: pixel (%0d, %0d) colour %h, expected %h",
				$time, x, y, got, exp);
		end
	endtask

	task automatic checkCoins(tankArenaPkg::coinCountT got, tankArenaPkg::coinCountT exp);
		if (got !== exp)
		begin
			coinErrors++;
			$display("[FAIL] %0t: coin count %0d, expected %0d", $time, got, exp);
		end
	endtask

	// Colour lands two edges after its pixel
	always
	begin
		@(posedge Master_Clock_In);
		#2;
		if (pipeValid[1])
			checkColor(pixelColor, pipeExp[1], pipeX[1], pipeY[1]);
		pipeValid[1] = pipeValid[0];
		pipeExp[1]   = pipeExp[0];
		pipeX[1]     = pipeX[0];
		pipeY[1]     = pipeY[0];
		pipeValid[0] = curValid;
		pipeExp[0]   = curExp;
		pipeX[0]     = curX;
		pipeY[0]     = curY;
	end

	////////////////////////////////
	// Stimulus tasks
	////////////////////////////////

	// One pixel per cycle, just after the edge
	task automatic drivePixel(logic ena, int x, int y, logic check);
		@(posedge Master_Clock_In);
		#1;
		dispEna  = ena;
		pixelX   = tankArenaPkg::coordT'(x);
		pixelY   = tankArenaPkg::coordT'(y);
		curValid = check;
		curExp   = expectedColor(ena, x, y);
		curX     = x & 1023;
		curY     = y & 1023;
	endtask

	task automatic resetDut();
		rstN = 1'b0;
		for (int i = 0; i < 5; i++)
			drivePixel(1'b0, 0, 0, 1'b0);
		rstN = 1'b1;
		resetModel();
	endtask

	// Pixels on and around the tank box, then end of frame and the step
	task automatic runFrame(tankArenaPkg::buttonsT press);
		int   tx;
		int   ty;
		logic sawAck;
		logic atRest;
		tx      = refX;
		ty      = refY;
		buttons = press;
		drivePixel(1'b1, tx, ty, 1'b1);
		drivePixel(1'b1, tx + `TANK_WIDTH, ty, 1'b1);
		drivePixel(1'b1, tx, ty + `TANK_WIDTH, 1'b1);
		drivePixel(1'b1, tx + `TANK_WIDTH, ty + `TANK_WIDTH, 1'b1);
		drivePixel(1'b1, tx - 1, ty, 1'b1);
		drivePixel(1'b1, tx + `TANK_WIDTH + 1, ty + 12, 1'b1);
		drivePixel(1'b1, tx + 12, ty - 1, 1'b1);
		drivePixel(1'b1, tx + 12, ty + `TANK_WIDTH + 1, 1'b1);
		drivePixel(1'b1, tx + 12, ty + 12, 1'b1);
		// Centre of the coin tile at column 2, row 1
		drivePixel(1'b1, 80, 48, 1'b1);
		drivePixel(1'b1, `SCREEN_WIDTH, `SCREEN_HEIGHT, 1'b0);
		sawAck = 1'b0;
		atRest = 1'b0;
		for (int n = 0; n < 12 && !atRest; n++)
		begin
			drivePixel(1'b0, 0, 0, 1'b0);
			if (UUT.stepAck)
				sawAck = 1'b1;
			else if (sawAck && !UUT.stepReq)
				atRest = 1'b1;
		end
		if (!atRest)
		begin
			timeoutErrors++;
			$display("Timeout at %0t: frame step handshake did not return to rest", $time);
		end
		applyStep(press);
		checkCoins(coinValue, tankArenaPkg::coinCountT'(refCoins));
	endtask

	task automatic repeatFrames(tankArenaPkg::buttonsT press, int count);
		for (int i = 0; i < count; i++)
			runFrame(press);
	endtask

	////////////////////////////////
	// Test sequence
	////////////////////////////////

	initial
	begin
		tankArenaPkg::buttonsT press;
		int pick;
		int total;
		void'($urandom(58884));
		rstN          = 1'b0;
		dispEna       = 1'b0;
		pixelX        = '0;
		pixelY        = '0;
		buttons       = '0;
		curValid      = 1'b0;
		curExp        = '0;
		curX          = 0;
		curY          = 0;
		pipeValid[0]  = 1'b0;
		pipeValid[1]  = 1'b0;
		colorErrors   = 0;
		coinErrors    = 0;
		timeoutErrors = 0;
		resetDut();

		// Blank, border and the whole start layout
		drivePixel(1'b0, 100, 100, 1'b1);
		drivePixel(1'b0, `SCREEN_WIDTH, `SCREEN_HEIGHT, 1'b1);
		drivePixel(1'b1, 641, 100, 1'b1);
		drivePixel(1'b1, 100, 481, 1'b1);
		drivePixel(1'b1, 1023, 1023, 1'b1);
		for (int r = 0; r < `MAP_ROWS; r++)
			for (int c = 0; c < `MAP_COLS; c++)
				drivePixel(1'b1, c * 32 + 16, r * 32 + 16, 1'b1);
		runFrame('0);

		// Random presses along row 0, right wins over down
		for (int i = 0; i < 6; i++)
		begin
			pick  = $urandom % 3;
			press = '0;
			if (pick == 0)
			begin
				press.right = 1'b1;
				press.down  = 1'b1;
			end
			else if (pick == 1)
				press.right = 1'b1;
			runFrame(press);
		end
		// Up wins over down
		for (int i = 0; i < 4; i++)
		begin
			pick  = $urandom % 2;
			press = '0;
			if (pick == 0)
			begin
				press.up   = 1'b1;
				press.down = 1'b1;
			end
			runFrame(press);
		end

		// Wrap on the left edge, then on the top edge
		resetDut();
		press      = '0;
		press.left = 1'b1;
		repeatFrames(press, 5);
		repeatFrames('0, 2);
		press    = '0;
		press.up = 1'b1;
		repeatFrames(press, 5);
		repeatFrames('0, 2);

		// Down into the brick at column 1, row 1
		resetDut();
		press       = '0;
		press.right = 1'b1;
		repeatFrames(press, 15);
		press      = '0;
		press.down = 1'b1;
		repeatFrames(press, 30);

		// Coin pickup, then touch the cleared tile again
		resetDut();
		press       = '0;
		press.right = 1'b1;
		repeatFrames(press, 65);
		press      = '0;
		press.down = 1'b1;
		repeatFrames(press, 4);
		press    = '0;
		press.up = 1'b1;
		repeatFrames(press, 2);
		press      = '0;
		press.down = 1'b1;
		repeatFrames(press, 2);
		repeatFrames('0, 1);
		checkCoins(coinValue, 8'd1);

		total = colorErrors + coinErrors + timeoutErrors;
		$display("Errors: colour %0d, coins %0d, timeouts %0d",
			colorErrors, coinErrors, timeoutErrors);
		if (total == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
+incdir+source
+incdir+test
source/tankArenaPkg.sv
source/tileMap.sv
source/pixelDecode.sv
source/tankMotion.sv
source/pixelShade.sv
source/tankArena.sv
test/tankArenaTb.sv
